/* verilog/decPkg.sv */
/*
Shared types for the 32-bit decoder. Register ids above 0x0F are pseudo
registers, and 0x7F means no register. The 64-bit and FPU ranges are not modeled.
*/

package decPkg;

	localparam int INSTR_W = 48;	// fetch window
	localparam int CMD_W = 16;
	localparam int REG_W = 7;
	localparam int IMM_W = 32;
	localparam int STEP_W = 4;

	typedef logic [INSTR_W-1:0] instrWord_t;
	typedef logic [CMD_W-1:0] cmdWord_t;
	typedef logic [REG_W-1:0] regId_t;
	typedef logic [IMM_W-1:0] imm_t;
	typedef logic [STEP_W-1:0] pcStep_t;

	localparam regId_t UREG_R0 = 7'h00;
	localparam regId_t UREG_R15 = 7'h0F;
	localparam regId_t UREG_ZZR = 7'h7F;	// no register
	localparam regId_t UREG_MR_IMM = 7'h7E;	// operand is the immediate
	localparam regId_t UREG_MR_MEMINC = 7'h7D;	// @Rm+
	localparam regId_t UREG_MR_MEMDEC = 7'h7C;	// @-Rn
	localparam regId_t UREG_PCW = 7'h7B;
	localparam regId_t UREG_PCL = 7'h7A;

	localparam logic [7:0] PFX_8E = 8'h8E;
	localparam logic [7:0] PFX_8A = 8'h8A;

	localparam pcStep_t PC_STEP16 = 4'd2;
	localparam pcStep_t PC_STEP32 = 4'd4;

	typedef enum logic [7:0] {
		UCMD_NONE = 8'h00,
		UCMD_UDBRK,
		UCMD_MOV_RR, UCMD_MOV_RI,
		UCMD_MOVB_RM, UCMD_MOVW_RM, UCMD_MOVL_RM,
		UCMD_MOVB_MR, UCMD_MOVW_MR, UCMD_MOVL_MR,
		UCMD_ALU_ADD, UCMD_ALU_SUB, UCMD_ALU_ADDC, UCMD_ALU_ADDV,
		UCMD_ALU_SUBC, UCMD_ALU_SUBV, UCMD_ALU_AND, UCMD_ALU_OR,
		UCMD_ALU_XOR, UCMD_ALU_MUL, UCMD_ALU_DMULS, UCMD_ALU_DMULU,
		UCMD_ALU_MULSW, UCMD_ALU_MULUW, UCMD_ALU_DIV0S, UCMD_ALU_DIV1,
		UCMD_ALU_CMPSTR, UCMD_ALU_XTRCT,
		UCMD_ALU_SHLL, UCMD_ALU_SHLR, UCMD_ALU_SHAL, UCMD_ALU_SHAR,
		UCMD_ALU_ROTL, UCMD_ALU_ROTR, UCMD_ALU_ROTCL, UCMD_ALU_ROTCR,
		UCMD_ALU_SHLD, UCMD_ALU_SHLDR, UCMD_ALU_SHAD, UCMD_ALU_SHADR,
		UCMD_ALU_DT, UCMD_ALU_MOVT, UCMD_ALU_SPOP,
		UCMD_CMP_EQ, UCMD_CMP_HS, UCMD_CMP_GE, UCMD_CMP_HI,
		UCMD_CMP_GT, UCMD_CMP_TST,
		UCMD_BRA, UCMD_BSR, UCMD_BT, UCMD_BF, UCMD_BTS, UCMD_BFS,
		UCMD_BRAN, UCMD_RTS, UCMD_RTE
	} uCmd_t;

	// special op selector, carried in imm[7:0]
	typedef enum logic [7:0] {
		SPOP_CLRT = 8'd0,
		SPOP_SETT = 8'd1,
		SPOP_CLRMAC = 8'd2,
		SPOP_CLRS = 8'd3,
		SPOP_SETS = 8'd4,
		SPOP_NOTT = 8'd5,
		SPOP_DIV0U = 8'd6,
		SPOP_SLEEP = 8'd7
	} spOp_t;

	typedef enum logic [4:0] {
		UXFORM_CST, UXFORM_Z, UXFORM_N, UXFORM_N_C,
		UXFORM_MOV_NS, UXFORM_MOV_NSO, UXFORM_MOV_NSJ,
		UXFORM_MOV_INC, UXFORM_MOV_DEC,
		UXFORM_ARI_NST, UXFORM_ARI_ST, UXFORM_CMP_ST,
		UXFORM_ARI_NNI, UXFORM_ARI_I8R0,
		UXFORM_BR_D8, UXFORM_BR_D12, UXFORM_PCREL, UXFORM_NST_8E
	} form_t;

	typedef struct packed {
		cmdWord_t cmdWord;
		logic [7:0] pfxByte;	// 8E payload byte
		logic [23:0] imm24;	// 8A payload
		logic isOp8E;
		logic isOp8A;
		pcStep_t stepPc;
		pcStep_t stepPc2;
	} decFields_t;

	typedef struct packed {
		uCmd_t uCmd;
		form_t form;
		imm_t ovrImm;
		logic ovrValid;
		pcStep_t stepPc;
	} decOp_t;

	typedef struct packed {
		regId_t regN;
		regId_t regS;
		regId_t regT;
		imm_t imm;
		uCmd_t uCmd;
		pcStep_t stepPc;
		pcStep_t stepPc2;
	} decOut_t;

	localparam decOut_t DEC_OUT_RST = '{
		regN: UREG_ZZR,
		regS: UREG_ZZR,
		regT: UREG_ZZR,
		imm: '0,
		uCmd: UCMD_NONE,
		stepPc: '0,
		stepPc2: '0
	};

	// plain GPR from an opcode nibble
	function automatic regId_t gprId(input logic [3:0] nib);
		return UREG_R0 | regId_t'(nib);
	endfunction

endpackage

/* verilog/opWordSplit.sv */
/*
Only the 8E and 8A prefixes start a 32-bit op. Bits 47:32 are looked at only
for the next-op step when a prefix is present.
*/

`timescale 1ns/1ps

module opWordSplit(
	input decPkg::instrWord_t istrWord,
	output decPkg::decFields_t fields
);

	logic [7:0] nextByte;	// high byte of the following op

	always_comb begin
		fields = '0;
		fields.imm24 = {istrWord[7:0], istrWord[31:16]};
		case (istrWord[15:8])
			decPkg::PFX_8E: begin
				fields.cmdWord = istrWord[31:16];
				fields.pfxByte = istrWord[7:0];
				fields.isOp8E = 1'b1;
				fields.stepPc = decPkg::PC_STEP32;
				nextByte = istrWord[47:40];
			end
			decPkg::PFX_8A: begin
				fields.cmdWord = istrWord[15:0];
				fields.isOp8A = 1'b1;
				fields.stepPc = decPkg::PC_STEP32;
				nextByte = istrWord[47:40];
			end
			default: begin
				fields.cmdWord = istrWord[15:0];
				fields.stepPc = decPkg::PC_STEP16;
				nextByte = istrWord[31:24];
			end
		endcase

		case (nextByte)
			decPkg::PFX_8A,
			8'h8C,	// escape, still a 32-bit op
			decPkg::PFX_8E: begin
				fields.stepPc2 = decPkg::PC_STEP32;
			end
			default: begin
				fields.stepPc2 = decPkg::PC_STEP16;
			end
		endcase
	end

endmodule

/* verilog/opClassify.sv */
/*
Unknown or reserved words decode as UDBRK. 0F3B is the only row that
yields a zero PC step, so the fetch stalls on it.
*/

`timescale 1ns/1ps

module opClassify(
	input decPkg::decFields_t fields,
	output decPkg::decOp_t op
);

	logic holdPc;

	function automatic decPkg::decOp_t mk(decPkg::uCmd_t c, decPkg::form_t f);
		decPkg::decOp_t o;
		o = '0;
		o.uCmd = c;
		o.form = f;
		return o;
	endfunction

	function automatic decPkg::decOp_t mkOvr(decPkg::uCmd_t c, decPkg::form_t f,
		decPkg::imm_t v);
		decPkg::decOp_t o;
		o = mk(c, f);
		o.ovrImm = v;
		o.ovrValid = 1'b1;
		return o;
	endfunction

	function automatic decPkg::decOp_t sp(decPkg::spOp_t s);
		return mkOvr(decPkg::UCMD_ALU_SPOP, decPkg::UXFORM_CST, {24'h0, s});
	endfunction

	// fixed-count shift as SHLD Rn by immediate
	function automatic decPkg::decOp_t shf(decPkg::imm_t cnt);
		return mkOvr(decPkg::UCMD_ALU_SHLD, decPkg::UXFORM_N_C, cnt);
	endfunction

	always_comb begin
		op = mk(decPkg::UCMD_UDBRK, decPkg::UXFORM_CST);
		holdPc = 1'b0;
		if (fields.isOp8A) begin
			op = mkOvr(decPkg::UCMD_MOV_RI, decPkg::UXFORM_CST,
				{{8{fields.imm24[23]}}, fields.imm24});
		end else begin
			casez (fields.cmdWord)
			16'h0zz4: op = mk(decPkg::UCMD_MOVB_RM, decPkg::UXFORM_MOV_NSO);
			16'h0zz5: op = mk(decPkg::UCMD_MOVW_RM, decPkg::UXFORM_MOV_NSO);
			16'h0zz6: op = mk(decPkg::UCMD_MOVL_RM, decPkg::UXFORM_MOV_NSO);
			16'h0zz7: op = mk(decPkg::UCMD_ALU_MUL, decPkg::UXFORM_ARI_ST);
			16'h0z08: op = sp(decPkg::SPOP_CLRT);
			16'h0z18: op = sp(decPkg::SPOP_SETT);
			16'h0z28: op = sp(decPkg::SPOP_CLRMAC);
			16'h0z48: op = sp(decPkg::SPOP_CLRS);
			16'h0z58: op = sp(decPkg::SPOP_SETS);
			16'h0z68: op = sp(decPkg::SPOP_NOTT);
			16'h0z09: op = mk(decPkg::UCMD_NONE, decPkg::UXFORM_Z);	// nop
			16'h0z19: op = sp(decPkg::SPOP_DIV0U);
			16'h0z29: op = mk(decPkg::UCMD_ALU_MOVT, decPkg::UXFORM_N);
			16'h0z0B: op = mk(decPkg::UCMD_RTS, decPkg::UXFORM_Z);
			16'h0z1B: op = sp(decPkg::SPOP_SLEEP);
			16'h0z2B: op = mk(decPkg::UCMD_RTE, decPkg::UXFORM_Z);
			16'h0z3B: begin	// breakpoint
				op = mkOvr(decPkg::UCMD_UDBRK, decPkg::UXFORM_Z, 32'd1);
				if (fields.cmdWord[11:8] == 4'hF) begin
					op.uCmd = decPkg::UCMD_NONE;	// hold in place
					holdPc = 1'b1;
				end
			end
			16'h0zzC: op = mk(decPkg::UCMD_MOVB_MR, decPkg::UXFORM_MOV_NSO);
			16'h0zzD: op = mk(decPkg::UCMD_MOVW_MR, decPkg::UXFORM_MOV_NSO);
			16'h0zzE: op = mk(decPkg::UCMD_MOVL_MR, decPkg::UXFORM_MOV_NSO);
			16'h1zzz: op = mk(decPkg::UCMD_MOVL_RM, decPkg::UXFORM_MOV_NSJ);
			16'h2zz0: op = mk(decPkg::UCMD_MOVB_RM, decPkg::UXFORM_MOV_NS);
			16'h2zz1: op = mk(decPkg::UCMD_MOVW_RM, decPkg::UXFORM_MOV_NS);
			16'h2zz2: op = mk(decPkg::UCMD_MOVL_RM, decPkg::UXFORM_MOV_NS);
			16'h2zz4: op = mk(decPkg::UCMD_MOVB_RM, decPkg::UXFORM_MOV_DEC);
			16'h2zz5: op = mk(decPkg::UCMD_MOVW_RM, decPkg::UXFORM_MOV_DEC);
			16'h2zz6: op = mk(decPkg::UCMD_MOVL_RM, decPkg::UXFORM_MOV_DEC);
			16'h2zz7: op = mk(decPkg::UCMD_ALU_DIV0S, decPkg::UXFORM_ARI_ST);
			16'h2zz8: op = mk(decPkg::UCMD_CMP_TST, decPkg::UXFORM_CMP_ST);
			16'h2zz9: op = mk(decPkg::UCMD_ALU_AND, decPkg::UXFORM_ARI_NST);
			16'h2zzA: op = mk(decPkg::UCMD_ALU_XOR, decPkg::UXFORM_ARI_NST);
			16'h2zzB: op = mk(decPkg::UCMD_ALU_OR, decPkg::UXFORM_ARI_NST);
			16'h2zzC: op = mk(decPkg::UCMD_ALU_CMPSTR, decPkg::UXFORM_ARI_NST);
			16'h2zzD: op = mk(decPkg::UCMD_ALU_XTRCT, decPkg::UXFORM_ARI_NST);
			16'h2zzE: op = mk(decPkg::UCMD_ALU_MULUW, decPkg::UXFORM_ARI_ST);
			16'h2zzF: op = mk(decPkg::UCMD_ALU_MULSW, decPkg::UXFORM_ARI_ST);
			16'h3zz0: op = mk(decPkg::UCMD_CMP_EQ, decPkg::UXFORM_CMP_ST);
			16'h3zz2: op = mk(decPkg::UCMD_CMP_HS, decPkg::UXFORM_CMP_ST);
			16'h3zz3: op = mk(decPkg::UCMD_CMP_GE, decPkg::UXFORM_CMP_ST);
			16'h3zz4: op = mk(decPkg::UCMD_ALU_DIV1, decPkg::UXFORM_ARI_NST);
			16'h3zz5: op = mk(decPkg::UCMD_ALU_DMULU, decPkg::UXFORM_ARI_ST);
			16'h3zz6: op = mk(decPkg::UCMD_CMP_HI, decPkg::UXFORM_CMP_ST);
			16'h3zz7: op = mk(decPkg::UCMD_CMP_GT, decPkg::UXFORM_CMP_ST);
			16'h3zz8: op = mk(decPkg::UCMD_ALU_SUB, decPkg::UXFORM_ARI_NST);
			16'h3zzA: op = mk(decPkg::UCMD_ALU_SUBC, decPkg::UXFORM_ARI_NST);
			16'h3zzB: op = mk(decPkg::UCMD_ALU_SUBV, decPkg::UXFORM_ARI_NST);
			16'h3zzC: op = mk(decPkg::UCMD_ALU_ADD, decPkg::UXFORM_ARI_NST);
			16'h3zzD: op = mk(decPkg::UCMD_ALU_DMULS, decPkg::UXFORM_ARI_ST);
			16'h3zzE: op = mk(decPkg::UCMD_ALU_ADDC, decPkg::UXFORM_ARI_NST);
			16'h3zzF: op = mk(decPkg::UCMD_ALU_ADDV, decPkg::UXFORM_ARI_NST);
			16'h4z00: op = mk(decPkg::UCMD_ALU_SHLL, decPkg::UXFORM_N);
			16'h4z10: op = mk(decPkg::UCMD_ALU_DT, decPkg::UXFORM_N);
			16'h4z20: op = mk(decPkg::UCMD_ALU_SHAL, decPkg::UXFORM_N);
			16'h4z01: op = mk(decPkg::UCMD_ALU_SHLR, decPkg::UXFORM_N);
			16'h4z21: op = mk(decPkg::UCMD_ALU_SHAR, decPkg::UXFORM_N);
			16'h4zz3: begin	// three-register ALU, prefixed only
				if (fields.isOp8E) begin
					case (fields.cmdWord[7:4])
						4'h0: op = mk(decPkg::UCMD_ALU_ADD, decPkg::UXFORM_NST_8E);
						4'h1: op = mk(decPkg::UCMD_ALU_SUB, decPkg::UXFORM_NST_8E);
						4'h2: op = mk(decPkg::UCMD_ALU_MUL, decPkg::UXFORM_NST_8E);
						4'h3: op = mk(decPkg::UCMD_ALU_AND, decPkg::UXFORM_NST_8E);
						4'h4: op = mk(decPkg::UCMD_ALU_OR, decPkg::UXFORM_NST_8E);
						4'h5: op = mk(decPkg::UCMD_ALU_XOR, decPkg::UXFORM_NST_8E);
						4'h6: op = mk(decPkg::UCMD_ALU_SHLD, decPkg::UXFORM_NST_8E);
						4'h7: op = mk(decPkg::UCMD_ALU_SHLDR, decPkg::UXFORM_NST_8E);
						4'h8: op = mk(decPkg::UCMD_ALU_SHAD, decPkg::UXFORM_NST_8E);
						4'h9: op = mk(decPkg::UCMD_ALU_SHADR, decPkg::UXFORM_NST_8E);
						default: ;
					endcase
				end
			end
			16'h4z04: op = mk(decPkg::UCMD_ALU_ROTL, decPkg::UXFORM_N);
			16'h4z24: op = mk(decPkg::UCMD_ALU_ROTCL, decPkg::UXFORM_N);
			16'h4z05: op = mk(decPkg::UCMD_ALU_ROTR, decPkg::UXFORM_N);
			16'h4z25: op = mk(decPkg::UCMD_ALU_ROTCR, decPkg::UXFORM_N);
			16'h4z08: op = shf(32'd2);
			16'h4z18: op = shf(32'd8);
			16'h4z28: op = shf(32'd16);
			16'h4z09: op = shf(32'hFFFF_FFFE);	// right shifts are negative
			16'h4z19: op = shf(32'hFFFF_FFF8);
			16'h4z29: op = shf(32'hFFFF_FFF0);
			16'h4zzC: op = mk(decPkg::UCMD_ALU_SHAD, decPkg::UXFORM_ARI_NST);
			16'h4zzD: op = mk(decPkg::UCMD_ALU_SHLD, decPkg::UXFORM_ARI_NST);
			16'h5zzz: op = mk(decPkg::UCMD_MOVL_MR, decPkg::UXFORM_MOV_NSJ);
			16'h6zz0: op = mk(decPkg::UCMD_MOVB_MR, decPkg::UXFORM_MOV_NS);
			16'h6zz1: op = mk(decPkg::UCMD_MOVW_MR, decPkg::UXFORM_MOV_NS);
			16'h6zz2: op = mk(decPkg::UCMD_MOVL_MR, decPkg::UXFORM_MOV_NS);
			16'h6zz3: op = mk(decPkg::UCMD_MOV_RR, decPkg::UXFORM_MOV_NS);
			16'h6zz4: op = mk(decPkg::UCMD_MOVB_MR, decPkg::UXFORM_MOV_INC);
			16'h6zz5: op = mk(decPkg::UCMD_MOVW_MR, decPkg::UXFORM_MOV_INC);
			16'h6zz6: op = mk(decPkg::UCMD_MOVL_MR, decPkg::UXFORM_MOV_INC);
			16'h7zzz: op = mk(decPkg::UCMD_ALU_ADD, decPkg::UXFORM_ARI_NNI);
			16'h82zz: op = mk(decPkg::UCMD_BRAN, decPkg::UXFORM_BR_D8);
			16'h88zz: op = mk(decPkg::UCMD_CMP_EQ, decPkg::UXFORM_ARI_I8R0);
			16'h89zz: op = mk(decPkg::UCMD_BT, decPkg::UXFORM_BR_D8);
			16'h8Bzz: op = mk(decPkg::UCMD_BF, decPkg::UXFORM_BR_D8);
			16'h8Dzz: op = mk(decPkg::UCMD_BTS, decPkg::UXFORM_BR_D8);
			16'h8Fzz: op = mk(decPkg::UCMD_BFS, decPkg::UXFORM_BR_D8);
			16'h9zzz: op = mk(decPkg::UCMD_MOVW_MR, decPkg::UXFORM_PCREL);
			16'hAzzz: op = mk(decPkg::UCMD_BRA, decPkg::UXFORM_BR_D12);
			16'hBzzz: op = mk(decPkg::UCMD_BSR, decPkg::UXFORM_BR_D12);
			16'hC8zz: op = mk(decPkg::UCMD_CMP_TST, decPkg::UXFORM_ARI_I8R0);
			16'hC9zz: op = mk(decPkg::UCMD_ALU_AND, decPkg::UXFORM_ARI_I8R0);
			16'hCAzz: op = mk(decPkg::UCMD_ALU_XOR, decPkg::UXFORM_ARI_I8R0);
			16'hCBzz: op = mk(decPkg::UCMD_ALU_OR, decPkg::UXFORM_ARI_I8R0);
			16'hDzzz: op = mk(decPkg::UCMD_MOVL_MR, decPkg::UXFORM_PCREL);
			16'hEzzz: op = mk(decPkg::UCMD_MOV_RI, decPkg::UXFORM_ARI_NNI);
			default: ;	// stays UDBRK
			endcase
		end
		op.stepPc = holdPc ? '0 : fields.stepPc;
	end

endmodule

/* verilog/operandForm.sv */
/*
Output is registered, one cycle after the word is sampled. Selectors a form
leaves unset read as ZZR, and an override immediate always wins.
*/

`timescale 1ns/1ps

module operandForm(
	input logic clk,
	input logic rstN,
	input decPkg::decFields_t fields,
	input decPkg::decOp_t op,
	output decPkg::decOut_t decOut
);

	decPkg::cmdWord_t cw;
	logic [7:0] pfx;
	decPkg::regId_t rn;
	decPkg::regId_t rm;
	decPkg::regId_t rt;
	decPkg::imm_t pfxSx;
	decPkg::decOut_t nxt;

	assign cw = fields.cmdWord;
	assign pfx = fields.pfxByte;
	assign rn = decPkg::gprId(cw[11:8]);
	assign rm = decPkg::gprId(cw[7:4]);
	assign rt = decPkg::gprId(cw[3:0]);
	assign pfxSx = {{24{pfx[7]}}, pfx};

	always_comb begin
		nxt.regN = decPkg::UREG_ZZR;
		nxt.regS = decPkg::UREG_ZZR;
		nxt.regT = decPkg::UREG_ZZR;
		nxt.imm = '0;
		nxt.uCmd = op.uCmd;
		nxt.stepPc = op.stepPc;
		nxt.stepPc2 = fields.stepPc2;

		case (op.form)
			decPkg::UXFORM_CST: begin
				if (fields.isOp8A)
					nxt.regN = decPkg::UREG_R0;	// 24-bit load target
			end
			decPkg::UXFORM_N, decPkg::UXFORM_N_C: begin
				nxt.regN = rn;
				nxt.regS = rn;
				if (op.form == decPkg::UXFORM_N_C)
					nxt.regT = decPkg::UREG_MR_IMM;
			end
			decPkg::UXFORM_MOV_NS: begin
				nxt.regN = rn;
				nxt.regS = rm;
				if (fields.isOp8E)
					nxt.imm = pfxSx;	// displacement from prefix
			end
			decPkg::UXFORM_MOV_NSO: begin
				nxt.regN = rn;
				nxt.regS = rm;
				if (fields.isOp8E) begin
					nxt.regT = decPkg::gprId(pfx[7:4]);
					nxt.imm = {28'h0, pfx[3:0]};
				end else begin
					nxt.regT = decPkg::UREG_R0;	// @(R0,Rm)
				end
			end
			decPkg::UXFORM_MOV_NSJ: begin
				nxt.regN = rn;
				nxt.regS = rm;
				if (fields.isOp8E) begin
					nxt.regT = rt;
					nxt.imm = pfxSx;
				end else begin
					nxt.imm = {28'h0, cw[3:0]};
				end
			end
			decPkg::UXFORM_MOV_INC, decPkg::UXFORM_MOV_DEC: begin
				nxt.regN = rn;
				nxt.regS = rm;
				nxt.regT = (op.form == decPkg::UXFORM_MOV_INC) ?
					decPkg::UREG_MR_MEMINC : decPkg::UREG_MR_MEMDEC;
			end
			decPkg::UXFORM_ARI_NST: begin
				nxt.regN = rn;
				if (fields.isOp8E) begin
					nxt.regS = rm;
					nxt.regT = decPkg::UREG_MR_IMM;
					nxt.imm = pfxSx;
				end else begin
					nxt.regS = rn;
					nxt.regT = rm;
				end
			end
			decPkg::UXFORM_ARI_ST: begin
				nxt.regN = rn;
				nxt.regS = rm;
			end
			decPkg::UXFORM_CMP_ST: begin
				nxt.regS = rn;
				if (fields.isOp8E) begin
					nxt.regT = decPkg::UREG_MR_IMM;
					nxt.imm = {{20{pfx[7]}}, pfx, cw[7:4]};
				end else begin
					nxt.regT = rm;
				end
			end
			decPkg::UXFORM_ARI_NNI: begin
				nxt.regN = rn;
				nxt.regS = rn;
				nxt.regT = decPkg::UREG_MR_IMM;
				nxt.imm = fields.isOp8E ? {{16{pfx[7]}}, pfx, cw[7:0]} :
					{{24{cw[7]}}, cw[7:0]};
			end
			decPkg::UXFORM_ARI_I8R0: begin
				nxt.regN = decPkg::UREG_R0;
				nxt.regS = decPkg::UREG_R0;
				nxt.regT = decPkg::UREG_MR_IMM;
				nxt.imm = {24'h0, cw[7:0]};	// zero extended
			end
			decPkg::UXFORM_BR_D8: begin
				nxt.imm = fields.isOp8E ? {{16{pfx[7]}}, pfx, cw[7:0]} :
					{{24{cw[7]}}, cw[7:0]};
			end
			decPkg::UXFORM_BR_D12: begin
				nxt.imm = fields.isOp8E ? {{12{pfx[7]}}, pfx, cw[11:0]} :
					{{20{cw[11]}}, cw[11:0]};
			end
			decPkg::UXFORM_PCREL: begin
				nxt.regN = rn;
				nxt.regS = cw[14] ? decPkg::UREG_PCL : decPkg::UREG_PCW;	// Dxxx vs 9xxx
				nxt.imm = {24'h0, cw[7:0]};
			end
			decPkg::UXFORM_NST_8E: begin
				nxt.regN = rn;
				nxt.regS = decPkg::gprId(pfx[7:4]);
				nxt.regT = decPkg::gprId(pfx[3:0]);
			end
			default: ;
		endcase

		if (op.ovrValid)
			nxt.imm = op.ovrImm;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decOut <= decPkg::DEC_OUT_RST;
		end else begin
			decOut <= nxt;
		end
	end

endmodule

/* verilog/instrDecode.sv */
/*
Free-running decoder with one cycle of latency and no stall input.
A new fetch window is taken on every rising clk edge.
*/

`timescale 1ns/1ps

module instrDecode(
	input logic clk,
	input logic rstN,
	input decPkg::instrWord_t istrWord,
	output decPkg::decOut_t decOut
);

	decPkg::decFields_t fields;
	decPkg::decOp_t op;

	opWordSplit uSplit(
		.istrWord(istrWord),
		.fields(fields)
	);

	opClassify uClassify(
		.fields(fields),
		.op(op)
	);

	operandForm uForm(
		.clk(clk),
		.rstN(rstN),
		.fields(fields),
		.op(op),
		.decOut(decOut)
	);

endmodule

/* test/decodeVectors.svh */
/*
Rows are: fetch window, regN, regS, regT, imm, uCmd, stepPc, stepPc2.
Plain 16-bit rows keep bits 47:16 clear, so the following op is a 16-bit one.
*/

`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

	task automatic fillVectors();
		logic [31:0] rnd;
		// base register forms
		addVec(48'h0000_0000_312C, 7'h01, 7'h01, 7'h02, 32'h0, decPkg::UCMD_ALU_ADD, 4'd2, 4'd2);
		addVec(48'h0000_0000_2452, 7'h04, 7'h05, decPkg::UREG_ZZR,
			32'h0, decPkg::UCMD_MOVL_RM, 4'd2, 4'd2);
		addVec(48'h0000_0000_3A77, decPkg::UREG_ZZR, 7'h0A, 7'h07,
			32'h0, decPkg::UCMD_CMP_GT, 4'd2, 4'd2);	// compare writes no reg
		addVec(48'h0000_0000_6386, 7'h03, 7'h08, decPkg::UREG_MR_MEMINC,
			32'h0, decPkg::UCMD_MOVL_MR, 4'd2, 4'd2);
		// immediates and displacements
		addVec(48'h0000_0000_73F0, 7'h03, 7'h03, decPkg::UREG_MR_IMM,
			32'hFFFF_FFF0, decPkg::UCMD_ALU_ADD, 4'd2, 4'd2);
		addVec(48'h0000_0000_E580, 7'h05, 7'h05, decPkg::UREG_MR_IMM,
			32'hFFFF_FF80, decPkg::UCMD_MOV_RI, 4'd2, 4'd2);
		addVec(48'h0000_0000_C9F3, decPkg::UREG_R0, decPkg::UREG_R0, decPkg::UREG_MR_IMM,
			32'h0000_00F3, decPkg::UCMD_ALU_AND, 4'd2, 4'd2);	// zero extended
		addNoRegs(48'h0000_0000_89FE, 32'hFFFF_FFFE, decPkg::UCMD_BT, 4'd2, 4'd2);
		addNoRegs(48'h0000_0000_A800, 32'hFFFF_F800, decPkg::UCMD_BRA, 4'd2, 4'd2);
		addVec(48'h0000_0000_4228, 7'h02, 7'h02, decPkg::UREG_MR_IMM,
			32'd16, decPkg::UCMD_ALU_SHLD, 4'd2, 4'd2);
		addVec(48'h0000_0000_4709, 7'h07, 7'h07, decPkg::UREG_MR_IMM,
			32'hFFFF_FFFE, decPkg::UCMD_ALU_SHLD, 4'd2, 4'd2);	// shlr2
		// 8E prefix
		addVec(48'h0000_4103_8E56, 7'h01, 7'h05, 7'h06, 32'h0, decPkg::UCMD_ALU_ADD, 4'd4, 4'd2);
		addVec(48'h0000_4323_8E9A, 7'h03, 7'h09, 7'h0A, 32'h0, decPkg::UCMD_ALU_MUL, 4'd4, 4'd2);
		addVec(48'h0000_7412_8EF0, 7'h04, 7'h04, decPkg::UREG_MR_IMM,
			32'hFFFF_F012, decPkg::UCMD_ALU_ADD, 4'd4, 4'd2);
		addVec(48'h0000_E234_8E12, 7'h02, 7'h02, decPkg::UREG_MR_IMM,
			32'h0000_1234, decPkg::UCMD_MOV_RI, 4'd4, 4'd2);
		addNoRegs(48'h0000_0000_4103, 32'h0, decPkg::UCMD_UDBRK, 4'd2, 4'd2);	// 4xx3 needs 8E
		// 8A load of R0
		addVec(48'h0000_1234_8A80, decPkg::UREG_R0, decPkg::UREG_ZZR, decPkg::UREG_ZZR,
			32'hFF80_1234, decPkg::UCMD_MOV_RI, 4'd4, 4'd2);
		addVec(48'h0000_5678_8A12, decPkg::UREG_R0, decPkg::UREG_ZZR, decPkg::UREG_ZZR,
			32'h0012_5678, decPkg::UCMD_MOV_RI, 4'd4, 4'd2);
		// next-slot byte decides stepPc2
		addNoRegs(48'h0000_8A00_0009, 32'h0, decPkg::UCMD_NONE, 4'd2, 4'd4);
		addNoRegs(48'h0000_8C00_0009, 32'h0, decPkg::UCMD_NONE, 4'd2, 4'd4);
		addNoRegs(48'h0000_8E00_0009, 32'h0, decPkg::UCMD_NONE, 4'd2, 4'd4);
		addNoRegs(48'h0000_8B00_0009, 32'h0, decPkg::UCMD_NONE, 4'd2, 4'd2);
		addVec(48'h8E00_4103_8E56, 7'h01, 7'h05, 7'h06, 32'h0, decPkg::UCMD_ALU_ADD, 4'd4, 4'd4);
		addVec(48'h8C00_1234_8A80, decPkg::UREG_R0, decPkg::UREG_ZZR, decPkg::UREG_ZZR,
			32'hFF80_1234, decPkg::UCMD_MOV_RI, 4'd4, 4'd4);
		addVec(48'h8D00_4103_8E56, 7'h01, 7'h05, 7'h06, 32'h0, decPkg::UCMD_ALU_ADD, 4'd4, 4'd2);
		// special ops
		addSpop(16'h0008, decPkg::SPOP_CLRT);
		addSpop(16'h0018, decPkg::SPOP_SETT);
		addSpop(16'h0028, decPkg::SPOP_CLRMAC);
		addSpop(16'h0048, decPkg::SPOP_CLRS);
		addSpop(16'h0058, decPkg::SPOP_SETS);
		addSpop(16'h0068, decPkg::SPOP_NOTT);
		addSpop(16'h0019, decPkg::SPOP_DIV0U);
		addSpop(16'h001B, decPkg::SPOP_SLEEP);
		addNoRegs(48'h0000_0000_003B, 32'd1, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
		addNoRegs(48'h0000_0000_0F3B, 32'd1, decPkg::UCMD_NONE, 4'd0, 4'd2);	// pc holds
		addNoRegs(48'h0000_0000_053B, 32'd1, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
		// reserved words, some with random low bits
		addNoRegs(48'h0000_0000_FFFF, 32'h0, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
		addNoRegs(48'h0000_0000_3009, 32'h0, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
		for (int k = 0; k < 3; k++) begin
			rnd = $urandom;
			addNoRegs({32'h0, 4'h3, rnd[7:0], 4'h1}, 32'h0, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
			addNoRegs({32'h0, 8'h87, rnd[15:8]}, 32'h0, decPkg::UCMD_UDBRK, 4'd2, 4'd2);
		end
	endtask

`endif

/* test/decodeTb.sv */
/*
Applies one fetch window per clock and checks its decode one cycle later.
Expected values come from the row table in decodeVectors.svh.
*/

`timescale 1ns/1ps

module decodeTb;

	typedef struct packed {
		decPkg::instrWord_t word;
		decPkg::regId_t regN;
		decPkg::regId_t regS;
		decPkg::regId_t regT;
		decPkg::imm_t imm;
		decPkg::uCmd_t uCmd;
		decPkg::pcStep_t stepPc;
		decPkg::pcStep_t stepPc2;
	} vecEntry_t;

	logic clk;
	logic rstN;
	decPkg::instrWord_t istrWord;
	decPkg::decOut_t decOut;

	vecEntry_t vecs[$];
	int errCount = 0;
	int checkCount = 0;
	int seedVal;
	int limitNs;

	instrDecode DUT(
		.clk(clk),
		.rstN(rstN),
		.istrWord(istrWord),
		.decOut(decOut)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic addVec(input decPkg::instrWord_t word, input decPkg::regId_t regN,
		input decPkg::regId_t regS, input decPkg::regId_t regT, input decPkg::imm_t imm,
		input decPkg::uCmd_t uCmd, input decPkg::pcStep_t stepPc,
		input decPkg::pcStep_t stepPc2);
		vecEntry_t e;
		e.word = word;
		e.regN = regN;
		e.regS = regS;
		e.regT = regT;
		e.imm = imm;
		e.uCmd = uCmd;
		e.stepPc = stepPc;
		e.stepPc2 = stepPc2;
		vecs.push_back(e);
	endtask

	// forms that leave every selector unset
	task automatic addNoRegs(input decPkg::instrWord_t word, input decPkg::imm_t imm,
		input decPkg::uCmd_t uCmd, input decPkg::pcStep_t stepPc,
		input decPkg::pcStep_t stepPc2);
		addVec(word, decPkg::UREG_ZZR, decPkg::UREG_ZZR, decPkg::UREG_ZZR, imm, uCmd,
			stepPc, stepPc2);
	endtask

	// code lands in imm[7:0]
	task automatic addSpop(input decPkg::cmdWord_t cw, input decPkg::spOp_t code);
		addNoRegs({32'h0, cw}, decPkg::imm_t'(code), decPkg::UCMD_ALU_SPOP, 4'd2, 4'd2);
	endtask

	`include "decodeVectors.svh"

	task automatic checkField(input string name, input string tag, input logic [47:0] got,
		input logic [47:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("FAIL %s (%s): got 0x%0h, expected 0x%0h", name, tag, got, exp);
		end
	endtask

	task automatic checkOut(input vecEntry_t e, input string tag);
		checkField("regN", tag, 48'(decOut.regN), 48'(e.regN));
		checkField("regS", tag, 48'(decOut.regS), 48'(e.regS));
		checkField("regT", tag, 48'(decOut.regT), 48'(e.regT));
		checkField("imm", tag, 48'(decOut.imm), 48'(e.imm));
		checkField("uCmd", tag, 48'(decOut.uCmd), 48'(e.uCmd));
		checkField("stepPc", tag, 48'(decOut.stepPc), 48'(e.stepPc));
		checkField("stepPc2", tag, 48'(decOut.stepPc2), 48'(e.stepPc2));
	endtask

	initial begin
		vecEntry_t rstExp;
		rstN = 1'b0;
		istrWord = 48'h0000_0000_312C;	// live word, reset must win
		seedVal = $urandom(59);
		fillVectors();

		rstExp = '0;
		rstExp.regN = decPkg::UREG_ZZR;
		rstExp.regS = decPkg::UREG_ZZR;
		rstExp.regT = decPkg::UREG_ZZR;
		rstExp.uCmd = decPkg::UCMD_NONE;
		repeat (2) begin
			@(posedge clk);
			#1;
			checkOut(rstExp, "reset");
		end
		rstN = 1'b1;

		// word i goes in, word i-1 comes out, every cycle
		for (int i = 0; i <= vecs.size(); i++) begin
			@(posedge clk);
			#1;
			if (i > 0)
				checkOut(vecs[i-1], $sformatf("vector %0d", i - 1));
			if (i < vecs.size())
				istrWord = vecs[i].word;
		end

		$display("decodeTb: %0d vectors, %0d checks, %0d errors", vecs.size(), checkCount,
			errCount);
		if (errCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// table is filled at time 0, so its size is known here
	initial begin
		#1;
		limitNs = (vecs.size() + 10) * 4;
		#(limitNs - 1);
		$display("watchdog: decode run did not finish within %0d ns", limitNs);
		$display("decodeTb: %0d checks, %0d errors", checkCount, errCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* sim.f */
+incdir+test
verilog/decPkg.sv
verilog/opWordSplit.sv
verilog/opClassify.sv
verilog/operandForm.sv
verilog/instrDecode.sv
test/decodeTb.sv
